// File: cmdControl/cmdSequencer.sv
`timescale 1ns/10ps

module cmdSequencer (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] button,      // Debounced button code
    input  logic       busy,        // Clear sweep running
    output logic       addrEntryEn, // Address field editable
    output logic       dataEntryEn, // Data field editable
    output logic       entryClr,    // Zero both fields, abort only
    output logic       wrReq,
    output logic       rdReq,
    output logic       sweepStart
);

    // Level encoding inside a command
    localparam logic [1:0] lvlSelect = 2'd0; // Command can still change
    localparam logic [1:0] lvlAddr   = 2'd1;
    localparam logic [1:0] lvlData   = 2'd2; // Write only

    ioMemPkg::cmdSel cmd;
    logic [1:0]      level;
    logic [1:0]      prevButton;
    logic            locked;
    logic            btnEdge;

    // ******************************
    // Button edge detect
    // ******************************

    // Sweep start pulse counts as busy, busy itself rises a cycle later
    assign locked = busy | sweepStart;

    // Only a press from idle acts, a held code acts once
    assign btnEdge = (prevButton == 2'b00) && (button != 2'b00) && !locked;

    always_ff @(posedge clk) begin
        if (rst) begin
            prevButton <= 2'b00;
        end else begin
            prevButton <= button; // Tracked even while locked
        end
    end

    // ******************************
    // Command and level state
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd        <= ioMemPkg::CmdClear;
            level      <= lvlSelect;
            entryClr   <= 1'b0;
            wrReq      <= 1'b0;
            rdReq      <= 1'b0;
            sweepStart <= 1'b0;
        end else begin
            // Pulses last one cycle
            entryClr   <= 1'b0;
            wrReq      <= 1'b0;
            rdReq      <= 1'b0;
            sweepStart <= 1'b0;

            if (btnEdge) begin
                case (button)
                    ioMemPkg::BtnNext: begin
                        if (level == lvlSelect) begin // Selection frozen once entry begins
                            case (cmd)
                                ioMemPkg::CmdClear: cmd <= ioMemPkg::CmdWrite;
                                ioMemPkg::CmdWrite: cmd <= ioMemPkg::CmdRead;
                                default:            cmd <= ioMemPkg::CmdClear;
                            endcase
                        end
                    end
                    ioMemPkg::BtnAdvance: begin
                        case (cmd)
                            ioMemPkg::CmdClear: begin
                                sweepStart <= 1'b1; // Single level command
                            end
                            ioMemPkg::CmdWrite: begin
                                if (level == lvlData) begin
                                    wrReq <= 1'b1; // Fields still hold addr and data
                                    level <= lvlSelect;
                                end else begin
                                    level <= level + 2'd1;
                                end
                            end
                            ioMemPkg::CmdRead: begin
                                if (level == lvlAddr) begin
                                    rdReq <= 1'b1;
                                    level <= lvlSelect;
                                end else begin
                                    level <= level + 2'd1;
                                end
                            end
                            default: begin
                                cmd   <= ioMemPkg::CmdClear; // Recover from unused code
                                level <= lvlSelect;
                            end
                        endcase
                    end
                    ioMemPkg::BtnAbort: begin
                        cmd      <= ioMemPkg::CmdClear;
                        level    <= lvlSelect;
                        entryClr <= 1'b1; // Next entry starts from zero digits
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Entry field enables follow the level
    assign addrEntryEn = (level == lvlAddr) &&
                         (cmd == ioMemPkg::CmdWrite || cmd == ioMemPkg::CmdRead);
    assign dataEntryEn = (level == lvlData) && (cmd == ioMemPkg::CmdWrite);

    // ******************************
    // Checks
    // ******************************

    // One memory operation at a time toward memControl and clearSweeper
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({wrReq, rdReq, sweepStart}));

    assert property (@(posedge clk) disable iff (rst)
        cmd inside {ioMemPkg::CmdClear, ioMemPkg::CmdWrite, ioMemPkg::CmdRead});

endmodule

// File: cmdControl/digitEntry.sv
`timescale 1ns/10ps

module digitEntry #(
    parameter int NUM_DIGITS = 4 // One switch per digit
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [NUM_DIGITS-1:0]                  sw,
    input  logic                                   en,  // Field selected for editing
    input  logic                                   clr, // Zero whole field
    output logic [NUM_DIGITS*ioMemPkg::DIGIT_W-1:0] value
);

    logic [NUM_DIGITS-1:0] swPrev;
    logic [NUM_DIGITS-1:0] swRise;

    // Previous state kept even when disabled,
    // so a switch already up at enable time does not count
    always_ff @(posedge clk) begin
        if (rst) begin
            swPrev <= '0;
        end else begin
            swPrev <= sw;
        end
    end

    assign swRise = sw & ~swPrev;

    // ******************************
    // Per digit wrap counters
    // ******************************

    for (genvar i = 0; i < NUM_DIGITS; i++) begin : gDigit
        logic [ioMemPkg::DIGIT_W-1:0] digit;

        always_ff @(posedge clk) begin
            if (rst || clr) begin
                digit <= '0;
            end else if (en && swRise[i]) begin
                if (digit == ioMemPkg::DIGIT_MAX) begin
                    digit <= '0; // F wraps to 0
                end else begin
                    digit <= digit + 1'b1;
                end
            end
        end

        // Digit i sits at nibble i, switch 0 is least significant
        assign value[i*ioMemPkg::DIGIT_W +: ioMemPkg::DIGIT_W] = digit;
    end

endmodule

// File: common/ioMemPkg.sv
package ioMemPkg;

    // ******************************
    // Command selection
    // ******************************

    // Selected front panel command, code 2'b11 unused
    typedef enum logic [1:0] {
        CmdClear = 2'b00, // Zero sweep over whole memory
        CmdWrite = 2'b01, // Address, data, then write
        CmdRead  = 2'b10  // Address, then read to display
    } cmdSel;

    // ******************************
    // Button codes
    // ******************************

    localparam logic [1:0] BtnNext    = 2'b01; // Cycle selected command
    localparam logic [1:0] BtnAdvance = 2'b10; // Step current command one level
    localparam logic [1:0] BtnAbort   = 2'b11; // Back to Clear at level 0

    // ******************************
    // Hex digit fields
    // ******************************

    localparam int DIGIT_W = 4; // One hex digit

    // Last value before wrap to 0
    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 4'hF;

    localparam int NUM_SW = 4; // Slide switches, one per digit

    // Address field is small, single entry level
    localparam int ADDR_DIGITS = 2;

    // Data word digits
    localparam int DATA_DIGITS = 4;

endpackage

// File: memControl/clearSweeper.sv
`timescale 1ns/10ps

module clearSweeper #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,    // One cycle pulse from sequencer
    output logic              busy,
    output logic              sweepWe,
    output logic [ADDR_W-1:0] sweepAddr
);

    localparam logic [ADDR_W-1:0] lastAddr = {ADDR_W{1'b1}};

    logic [ADDR_W-1:0] addrCnt;

    // ******************************
    // Sweep counter
    // ******************************

    // Busy rises the cycle after start, one word per cycle,
    // high for exactly 2**ADDR_W cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            addrCnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            addrCnt <= '0; // Always begin at word 0
        end else if (busy) begin
            if (addrCnt == lastAddr) begin
                busy <= 1'b0; // Last word written this cycle
            end
            addrCnt <= addrCnt + 1'b1; // Rolls back to 0 after last
        end
    end

    assign sweepWe   = busy; // Zero write on every busy cycle
    assign sweepAddr = addrCnt;

    // Sequencer locks buttons during the sweep
    assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

// File: memControl/memControl.sv
`timescale 1ns/10ps

module memControl #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              wrReq,     // Write pulse from sequencer
    input  logic              rdReq,     // Read pulse from sequencer
    input  logic [ADDR_W-1:0] addr,      // Address entry field
    input  logic [DATA_W-1:0] wrData,    // Data entry field
    input  logic              sweepWe,
    input  logic [ADDR_W-1:0] sweepAddr,
    input  logic              rst,
    output logic [DATA_W-1:0] dispData
);

    localparam int depth = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [depth];

    logic              memWe;
    logic [ADDR_W-1:0] memAddr;
    logic [DATA_W-1:0] memWrData;

    // ******************************
    // Write source select
    // ******************************

    // Sweep owns the port while it runs, otherwise the command side
    always_comb begin
        if (sweepWe) begin
            memWe     = 1'b1;
            memAddr   = sweepAddr;
            memWrData = '0; // Clear writes zeros
        end else begin
            memWe     = wrReq;
            memAddr   = addr;
            memWrData = wrData;
        end
    end

    // Write lands at the edge that samples the request
    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[memAddr] <= memWrData;
        end
    end

    // ******************************
    // Display read register
    // ******************************

    // Word visible the cycle after rdReq is sampled, held until next read
    always_ff @(posedge clk) begin
        if (rst) begin
            dispData <= '0;
        end else if (rdReq) begin
            dispData <= mem[addr];
        end
    end

    // Sequencer and sweeper never overlap on the write port
    assert property (@(posedge clk) disable iff (rst)
        !(sweepWe && wrReq));

endmodule

// File: rtl/ioMemTop.sv
`timescale 1ns/10ps

module ioMemTop #(
    parameter int ADDR_W = ioMemPkg::ADDR_DIGITS * ioMemPkg::DIGIT_W, // 8
    parameter int DATA_W = ioMemPkg::DATA_DIGITS * ioMemPkg::DIGIT_W  // 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [1:0]                  button,
    input  logic [ioMemPkg::NUM_SW-1:0] sw,
    output logic                        memBusy,
    output logic [DATA_W-1:0]           dispData
);

    logic              addrEntryEn;
    logic              dataEntryEn;
    logic              entryClr;
    logic              wrReq;
    logic              rdReq;
    logic              sweepStart;
    logic              busy;
    logic              sweepWe;
    logic [ADDR_W-1:0] sweepAddr;
    logic [ADDR_W-1:0] addrValue; // Address field digits
    logic [DATA_W-1:0] dataValue; // Data field digits

    // ******************************
    // Front panel side
    // ******************************

    cmdSequencer u_cmdSequencer (
        .clk         (clk),
        .rst         (rst),
        .button      (button),
        .busy        (busy),
        .addrEntryEn (addrEntryEn),
        .dataEntryEn (dataEntryEn),
        .entryClr    (entryClr),
        .wrReq       (wrReq),
        .rdReq       (rdReq),
        .sweepStart  (sweepStart)
    );

    // Low switches only, address is two digits
    digitEntry #(.NUM_DIGITS(ioMemPkg::ADDR_DIGITS)) addrEntry (
        .clk   (clk),
        .rst   (rst),
        .sw    (sw[ioMemPkg::ADDR_DIGITS-1:0]),
        .en    (addrEntryEn),
        .clr   (entryClr),
        .value (addrValue)
    );

    digitEntry #(.NUM_DIGITS(ioMemPkg::DATA_DIGITS)) dataEntry (
        .clk   (clk),
        .rst   (rst),
        .sw    (sw),
        .en    (dataEntryEn),
        .clr   (entryClr),
        .value (dataValue)
    );

    // ******************************
    // Memory side
    // ******************************

    clearSweeper #(.ADDR_W(ADDR_W)) u_clearSweeper (
        .clk       (clk),
        .rst       (rst),
        .start     (sweepStart),
        .busy      (busy),
        .sweepWe   (sweepWe),
        .sweepAddr (sweepAddr)
    );

    memControl #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_memControl (
        .clk       (clk),
        .wrReq     (wrReq),
        .rdReq     (rdReq),
        .addr      (addrValue),
        .wrData    (dataValue),
        .sweepWe   (sweepWe),
        .sweepAddr (sweepAddr),
        .rst       (rst),
        .dispData  (dispData)
    );

    assign memBusy = busy; // Panel LED, high during Clear

endmodule

// File: src.f
common/ioMemPkg.sv
cmdControl/cmdSequencer.sv
cmdControl/digitEntry.sv
memControl/clearSweeper.sv
memControl/memControl.sv
rtl/ioMemTop.sv
tb/ioMemTb.sv

// File: tb/ioMemTb.sv
`timescale 1ns/10ps

module ioMemTb;

    localparam int DW          = ioMemPkg::DIGIT_W;
    localparam int ADDR_W      = ioMemPkg::ADDR_DIGITS * DW;
    localparam int DATA_W      = ioMemPkg::DATA_DIGITS * DW;
    localparam int RISE_LIMIT  = 8;   // Cycles allowed for memBusy to rise
    localparam int SWEEP_LIMIT = 400; // Sweep is 256 cycles
    localparam int CHECK_LIMIT = 8;
    localparam int CMD_CLEAR   = 0;   // Selection order Clear, Write, Read
    localparam int CMD_WRITE   = 1;
    localparam int CMD_READ    = 2;

    logic                        clk;
    logic                        rst;
    logic [1:0]                  button;
    logic [ioMemPkg::NUM_SW-1:0] sw;
    logic                        memBusy;
    logic [DATA_W-1:0]           dispData;

    // Reference model
    logic [DATA_W-1:0] refMem [2**ADDR_W];
    logic [ADDR_W-1:0] addrField; // Entry fields keep their digits between commands
    logic [DATA_W-1:0] dataField;
    int                cmdModel;

    integer            seed;
    int                mismatchCount;
    int                timeoutCount;
    logic              checkReq; // Read result ready for the checker
    logic [ADDR_W-1:0] checkAddr;
    string             checkName;

    ioMemTop u_ioMemTop (
        .clk      (clk),
        .rst      (rst),
        .button   (button),
        .sw       (sw),
        .memBusy  (memBusy),
        .dispData (dispData)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ******************************
    // Model and checks
    // ******************************

    function automatic logic [DATA_W-1:0] expectWord(input logic [ADDR_W-1:0] addr);
        return refMem[addr];
    endfunction

    // One rising edge per step, F wraps to 0
    function automatic logic [DW-1:0] wrapDigit(input logic [DW-1:0] d, input int count);
        logic [DW-1:0] r;
        r = d;
        for (int n = 0; n < count; n++) begin
            r = (r == {DW{1'b1}}) ? '0 : r + 1'b1;
        end
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        assert (actual === expected) else begin
            mismatchCount++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Compares on the rising edge, stimulus only moves on the falling one
    always @(posedge clk) begin
        if (checkReq) begin
            checkValue(checkName, expectWord(checkAddr), dispData);
            checkReq = 1'b0;
        end
    end

    // ******************************
    // Panel actions
    // ******************************

    task automatic pressButton(input logic [1:0] code);
        button = code;
        @(negedge clk);
        button = 2'b00; // Release so the next press is a new edge
        @(negedge clk);
    endtask

    task automatic toggleDigit(input logic isData, input int idx, input int count);
        for (int n = 0; n < count; n++) begin
            sw[idx] = 1'b1;
            @(negedge clk);
            sw[idx] = 1'b0;
            @(negedge clk);
        end
        if (isData) begin
            dataField[idx*DW +: DW] = wrapDigit(dataField[idx*DW +: DW], count);
        end else begin
            addrField[idx*DW +: DW] = wrapDigit(addrField[idx*DW +: DW], count);
        end
    endtask

    // Steps each digit from its current value to the target
    task automatic enterDigits(input logic isData, input logic [DATA_W-1:0] target);
        int            numDigits;
        logic [DW-1:0] steps;
        numDigits = isData ? ioMemPkg::DATA_DIGITS : ioMemPkg::ADDR_DIGITS;
        for (int i = 0; i < numDigits; i++) begin
            if (isData) begin
                steps = target[i*DW +: DW] - dataField[i*DW +: DW];
            end else begin
                steps = target[i*DW +: DW] - addrField[i*DW +: DW];
            end
            toggleDigit(isData, i, steps);
        end
    endtask

    task automatic selectCmd(input int target);
        while (cmdModel != target) begin // At most two presses
            pressButton(ioMemPkg::BtnNext);
            cmdModel = (cmdModel + 1) % 3;
        end
    endtask

    task automatic abortEntry();
        pressButton(ioMemPkg::BtnAbort);
        cmdModel  = CMD_CLEAR;
        addrField = '0; // Both fields zeroed
        dataField = '0;
    endtask

    // Leaves the panel at the data entry level
    task automatic beginWrite(input logic [ADDR_W-1:0] addr);
        selectCmd(CMD_WRITE);
        pressButton(ioMemPkg::BtnAdvance); // Address level
        enterDigits(1'b0, addr);
        pressButton(ioMemPkg::BtnAdvance); // Data level
    endtask

    task automatic issueWrite();
        pressButton(ioMemPkg::BtnAdvance);
        refMem[addrField] = dataField;
    endtask

    task automatic writeWord(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        beginWrite(addr);
        enterDigits(1'b1, data);
        issueWrite();
    endtask

    task automatic readWord(input logic [ADDR_W-1:0] addr, input string name);
        int cycles;
        selectCmd(CMD_READ);
        pressButton(ioMemPkg::BtnAdvance);
        enterDigits(1'b0, addr);
        pressButton(ioMemPkg::BtnAdvance); // Word on dispData once this returns
        checkAddr = addrField;
        checkName = name;
        checkReq  = 1'b1;
        cycles    = 0;
        while (checkReq && cycles < CHECK_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (!checkReq) else begin
            timeoutCount++;
            $display("ERROR: the read check for %s was never taken", name);
            checkReq = 1'b0;
        end
    endtask

    task automatic runClear(input string name);
        int cycles;
        int highCycles;
        selectCmd(CMD_CLEAR);
        pressButton(ioMemPkg::BtnAdvance);
        cycles = 0;
        while (!memBusy && cycles < RISE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (memBusy) else begin
            timeoutCount++;
            $display("ERROR: memBusy did not rise after the Clear command in %s", name);
        end
        highCycles = 0;
        while (memBusy && highCycles < SWEEP_LIMIT) begin
            @(negedge clk);
            highCycles++;
        end
        assert (!memBusy) else begin
            timeoutCount++;
            $display("ERROR: memBusy stayed high, the sweep in %s never ended", name);
        end
        if (cycles < RISE_LIMIT) begin
            checkValue({name, "_busy_cycles"}, 2**ADDR_W, highCycles);
        end
        for (int a = 0; a < 2**ADDR_W; a++) begin
            refMem[a] = '0;
        end
    endtask

    // ******************************
    // Test sequence
    // ******************************

    initial begin
        logic [ADDR_W-1:0] addrList [8];
        logic [DATA_W-1:0] dataList [8];
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [DATA_W-1:0] d;
        seed          = 32'hd8815e7b;
        rst           = 1'b1;
        button        = 2'b00;
        sw            = '0;
        checkReq      = 1'b0;
        mismatchCount = 0;
        timeoutCount  = 0;
        cmdModel      = CMD_CLEAR;
        addrField     = '0;
        dataField     = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        checkValue("reset_busy", '0, memBusy);
        checkValue("reset_disp", '0, dispData);

        runClear("clear");
        for (int i = 0; i < 5; i++) begin
            readWord($random(seed), "clear_read");
        end

        // Several words, read back after all are written
        for (int i = 0; i < 8; i++) begin
            addrList[i] = $random(seed);
            dataList[i] = $random(seed);
            writeWord(addrList[i], dataList[i]);
            if (i == 0) begin
                readWord(addrList[0], "write_read_now");
            end
        end
        for (int i = 7; i >= 0; i--) begin
            readWord(addrList[i], "write_read_later");
        end

        // Seventeen rises on the top data switch leave that digit at 1
        a = $random(seed);
        beginWrite(a);
        enterDigits(1'b1, '0);
        toggleDigit(1'b1, ioMemPkg::DATA_DIGITS - 1, 17);
        issueWrite();
        readWord(a, "digit_wrap");

        // Abort halfway through data entry
        a = $random(seed);
        d = $random(seed);
        writeWord(a, d);
        beginWrite(a);
        enterDigits(1'b1, ~d);
        abortEntry();
        readWord(a, "abort_keeps_word");
        b = a + 8'd1; // Neighbour word, data entered from zero digits
        d = $random(seed);
        writeWord(b, d);
        readWord(b, "write_after_abort");
        readWord(a, "abort_neighbour");

        // Three Next presses come back to Clear
        abortEntry();
        for (int i = 0; i < 3; i++) begin
            pressButton(ioMemPkg::BtnNext);
            cmdModel = (cmdModel + 1) % 3;
        end
        runClear("next_cycle_clear");
        readWord(b, "cycle_clear_read");

        $display("Errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount + timeoutCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
